// File: include/jesd204_up_params.svh
// register map addresses, version word and bus widths
// for the jesd204 processor-side register block.

`ifndef JESD204_UP_PARAMS_SVH
`define JESD204_UP_PARAMS_SVH

// ################################################
// bus widths
// ################################################

`define JESD204_UP_ADDR_W 12                // register address width.
`define JESD204_UP_DATA_W 32                // register data width.

// read-only identification word.
`define JESD204_UP_VERSION 32'h0001_0461    // major 1, minor 04, patch a.

// ################################################
// register addresses
// ################################################

`define JESD204_ADDR_VERSION       12'h000  // version, read only.
`define JESD204_ADDR_SCRATCH       12'h002  // free scratch word.
`define JESD204_ADDR_LINK_ENABLE   12'h010  // bit 0 enables the link.
`define JESD204_ADDR_MULTIFRAME    12'h011  // beats per multiframe.
`define JESD204_ADDR_SYSREF_CONF   12'h040  // oneshot and disable.
`define JESD204_ADDR_LMFC_OFFSET   12'h041  // lmfc offset, aligned.
`define JESD204_ADDR_SYSREF_STATUS 12'h042  // sticky events, w1c.

// octets per beat as log2, used to align the lmfc offset.
`define JESD204_DATA_PATH_WIDTH_LOG2 2

`endif

// File: logic/jesd204_up_pkg.sv
// shared packed types of the jesd204 register block:
// register write bundle, sysref configuration and device events.

`default_nettype none

`include "jesd204_up_params.svh"

package jesd204_up_pkg;

  // ################################################
  // register bus
  // ################################################

  // one register write, sampled on the rising edge of up_clk.
  typedef struct packed {
    logic                          wreq;   // write strobe.
    logic [`JESD204_UP_ADDR_W-1:0] waddr;  // word address.
    logic [`JESD204_UP_DATA_W-1:0] wdata;  // write data.
  } up_wr_t;

  // ################################################
  // sysref handling
  // ################################################

  // configuration, quasi-static towards device_clk.
  typedef struct packed {
    logic       oneshot;         // accept the first edge only.
    logic       sysref_disable;  // ignore every edge.
    logic [7:0] lmfc_offset;     // lmfc phase at the sysref edge, in beats.
  } sysref_cfg_t;

  // single-cycle device events, bit order matches the status register.
  typedef struct packed {
    logic alignment_error;  // edge seen off the expected lmfc phase.
    logic sysref_edge;      // an edge was accepted.
  } sysref_event_t;

endpackage

`default_nettype wire

// File: logic/sync_event.sv
// moves single-cycle event pulses between clock domains.
// each event becomes a toggle that passes a three-stage synchronizer.

`timescale 1ns/10ps
`default_nettype none

module sync_event #(
  parameter int NUM_OF_EVENTS = 1
) (
  input  wire logic                     in_clk,
  input  wire logic [NUM_OF_EVENTS-1:0] in_event,
  input  wire logic                     out_clk,
  output logic      [NUM_OF_EVENTS-1:0] out_event
);

  // ################################################
  // source domain
  // ################################################

  // no reset in either domain, the flops power up cleared.
  logic [NUM_OF_EVENTS-1:0] in_toggle = '0;

  always_ff @(posedge in_clk) begin
    in_toggle <= in_toggle ^ in_event;  // flip on each pulse.
  end

  // ################################################
  // destination domain
  // ################################################

  logic [NUM_OF_EVENTS-1:0] out_sync_1 = '0;  // metastable stage.
  logic [NUM_OF_EVENTS-1:0] out_sync_2 = '0;
  logic [NUM_OF_EVENTS-1:0] out_sync_3 = '0;
  logic [NUM_OF_EVENTS-1:0] out_toggle_d = '0;  // last seen toggle.
  logic [NUM_OF_EVENTS-1:0] out_event_r = '0;

  always_ff @(posedge out_clk) begin
    out_sync_1   <= in_toggle;
    out_sync_2   <= out_sync_1;
    out_sync_3   <= out_sync_2;
    out_toggle_d <= out_sync_3;
    out_event_r  <= out_sync_3 ^ out_toggle_d;  // one pulse per change.
  end

  assign out_event = out_event_r;

endmodule

`default_nettype wire

// File: logic/jesd204_up_common.sv
// common registers: version, scratch, link enable and multiframe length.
// also derives the qualifier that blocks configuration writes while enabled.

`timescale 1ns/10ps
`default_nettype none

`include "jesd204_up_params.svh"

module jesd204_up_common (
  input  wire logic                          up_clk,
  input  wire logic                          up_reset,
  input  wire logic [`JESD204_UP_ADDR_W-1:0] up_raddr,
  input  wire jesd204_up_pkg::up_wr_t        up_wr,
  output logic      [`JESD204_UP_DATA_W-1:0] up_rdata,
  output logic                               link_enable,
  output logic                               up_cfg_is_writeable,
  output logic      [7:0]                    beats_per_multiframe
);

  logic [`JESD204_UP_DATA_W-1:0] up_scratch;  // scratch word.

  // config may only change while the link is down.
  assign up_cfg_is_writeable = ~link_enable;

  // ################################################
  // write side
  // ################################################

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      up_scratch           <= '0;
      link_enable          <= 1'b0;
      beats_per_multiframe <= 8'd16;  // default multiframe length.
    end else if (up_wr.wreq) begin
      case (up_wr.waddr)
        `JESD204_ADDR_SCRATCH: begin
          up_scratch <= up_wr.wdata;  // always writable.
        end
        `JESD204_ADDR_LINK_ENABLE: begin
          link_enable <= up_wr.wdata[0];  // always writable.
        end
        `JESD204_ADDR_MULTIFRAME: begin
          if (up_cfg_is_writeable) begin
            beats_per_multiframe <= up_wr.wdata[7:0];
          end
        end
        default: begin
        end
      endcase
    end
  end

  // ################################################
  // read side
  // ################################################

  always_comb begin
    up_rdata = '0;  // unmapped reads zero.
    case (up_raddr)
      `JESD204_ADDR_VERSION:     up_rdata = `JESD204_UP_VERSION;
      `JESD204_ADDR_SCRATCH:     up_rdata = up_scratch;
      `JESD204_ADDR_LINK_ENABLE: up_rdata[0] = link_enable;
      `JESD204_ADDR_MULTIFRAME:  up_rdata[7:0] = beats_per_multiframe;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/jesd204_up_sysref.sv
// sysref configuration registers (oneshot, disable, lmfc offset)
// and the sticky write-one-to-clear status of sysref events.

`timescale 1ns/10ps
`default_nettype none

`include "jesd204_up_params.svh"

module jesd204_up_sysref #(
  parameter int DATA_PATH_WIDTH_LOG2 = 0  // 0 to 2.
) (
  input  wire logic                          up_clk,
  input  wire logic                          up_reset,
  input  wire logic [`JESD204_UP_ADDR_W-1:0] up_raddr,
  input  wire jesd204_up_pkg::up_wr_t        up_wr,
  input  wire logic                          up_cfg_is_writeable,
  input  wire jesd204_up_pkg::sysref_event_t up_sysref_event,
  output logic      [`JESD204_UP_DATA_W-1:0] up_rdata,
  output jesd204_up_pkg::sysref_cfg_t        sysref_cfg
);

  logic [1:0] up_sysref_status;        // bit 1 align error, bit 0 edge.
  logic [1:0] up_sysref_status_clear;  // w1c mask, one cycle.

  // ################################################
  // configuration
  // ################################################

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      sysref_cfg <= '0;
    end else if (up_wr.wreq && up_cfg_is_writeable) begin
      case (up_wr.waddr)
        `JESD204_ADDR_SYSREF_CONF: begin
          sysref_cfg.oneshot        <= up_wr.wdata[1];
          sysref_cfg.sysref_disable <= up_wr.wdata[0];
        end
        `JESD204_ADDR_LMFC_OFFSET: begin
          // low bits below the data path width are dropped.
          sysref_cfg.lmfc_offset <= up_wr.wdata[DATA_PATH_WIDTH_LOG2 +: 8];
        end
        default: begin
        end
      endcase
    end
  end

  // ################################################
  // status
  // ################################################

  always_comb begin
    up_sysref_status_clear = 2'b00;
    if (up_wr.wreq && up_wr.waddr == `JESD204_ADDR_SYSREF_STATUS) begin
      up_sysref_status_clear = up_wr.wdata[1:0];  // clear is never gated.
    end
  end

  // a new event in the clear cycle keeps its bit set.
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      up_sysref_status <= 2'b00;
    end else begin
      up_sysref_status <= (up_sysref_status & ~up_sysref_status_clear) |
                          up_sysref_event;
    end
  end

  // ################################################
  // read side
  // ################################################

  always_comb begin
    up_rdata = '0;  // zero outside this block.
    case (up_raddr)
      `JESD204_ADDR_SYSREF_CONF: begin
        up_rdata[1] = sysref_cfg.oneshot;
        up_rdata[0] = sysref_cfg.sysref_disable;
      end
      `JESD204_ADDR_LMFC_OFFSET: begin
        // alignment bits read back as zero.
        up_rdata[DATA_PATH_WIDTH_LOG2 +: 8] = sysref_cfg.lmfc_offset;
      end
      `JESD204_ADDR_SYSREF_STATUS: begin
        up_rdata[1:0] = up_sysref_status;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/jesd204_lmfc.sv
// device clock lmfc counter with sysref edge capture and alignment check.
// all state is held clear while the synchronized link enable is low.

`timescale 1ns/10ps
`default_nettype none

module jesd204_lmfc #(
  parameter int DATA_PATH_WIDTH_LOG2 = 0
) (
  input  wire logic                          device_clk,
  input  wire logic                          link_enable,  // up_clk level.
  input  wire logic                          sysref,
  input  wire jesd204_up_pkg::sysref_cfg_t   sysref_cfg,
  input  wire logic [7:0]                    beats_per_multiframe,
  output logic                               lmfc_edge,
  output jesd204_up_pkg::sysref_event_t      device_event
);

  // counter runs in octets, one beat advances 2**log2 octets.
  localparam int CNT_W = 8 + DATA_PATH_WIDTH_LOG2;
  localparam logic [CNT_W-1:0] STEP = CNT_W'(1) << DATA_PATH_WIDTH_LOG2;

  logic [1:0]       link_enable_sync = '0;  // enable synchronizer.
  logic [2:0]       sysref_r = '0;          // two sync stages, one history.
  logic             sysref_rise;
  logic             sysref_accept;
  logic             sysref_captured;        // first edge seen, check armed.
  logic [CNT_W-1:0] lmfc_counter;
  logic [CNT_W-1:0] lmfc_last;              // octet position of last beat.
  logic [CNT_W-1:0] lmfc_offset_pos;        // offset in octets.
  logic [CNT_W-1:0] lmfc_next;
  logic [CNT_W-1:0] lmfc_next_aligned;      // successor of the offset.

  // event pulses, clear from power up for the toggle synchronizer.
  jesd204_up_pkg::sysref_event_t device_event_r = '0;

  // ################################################
  // synchronizers
  // ################################################

  always_ff @(posedge device_clk) begin
    link_enable_sync <= {link_enable_sync[0], link_enable};
    sysref_r         <= {sysref_r[1:0], sysref};  // free running.
  end

  assign sysref_rise = sysref_r[1] & ~sysref_r[2];

  // oneshot drops every edge after the first, disable drops all.
  assign sysref_accept = sysref_rise && !sysref_cfg.sysref_disable &&
                         !(sysref_cfg.oneshot && sysref_captured);

  // ################################################
  // lmfc counter
  // ################################################

  assign lmfc_last       = CNT_W'(beats_per_multiframe - 8'd1) << DATA_PATH_WIDTH_LOG2;
  assign lmfc_offset_pos = CNT_W'(sysref_cfg.lmfc_offset) << DATA_PATH_WIDTH_LOG2;

  always_comb begin
    lmfc_next = lmfc_counter + STEP;
    if (lmfc_counter >= lmfc_last) begin
      lmfc_next = '0;  // wrap at multiframe end.
    end
    lmfc_next_aligned = lmfc_offset_pos + STEP;
    if (lmfc_offset_pos >= lmfc_last) begin
      lmfc_next_aligned = '0;
    end
  end

  // the edge cycle is taken as phase lmfc_offset.
  always_ff @(posedge device_clk) begin
    if (!link_enable_sync[1]) begin
      lmfc_counter    <= '0;
      sysref_captured <= 1'b0;
      lmfc_edge       <= 1'b0;
      device_event_r  <= '0;
    end else begin
      lmfc_edge      <= (lmfc_counter == '0);  // one pulse per multiframe.
      device_event_r <= '0;
      if (sysref_accept) begin
        lmfc_counter                   <= lmfc_next_aligned;  // realign.
        sysref_captured                <= 1'b1;
        device_event_r.sysref_edge     <= 1'b1;
        device_event_r.alignment_error <= sysref_captured &&
                                          (lmfc_counter != lmfc_offset_pos);
      end else begin
        lmfc_counter <= lmfc_next;
      end
    end
  end

  assign device_event = device_event_r;

endmodule

`default_nettype wire

// File: logic/jesd204_up_regmap.sv
// top of the jesd204 register block: common and sysref registers,
// event synchronizer, device clock lmfc logic and the read data or.

`timescale 1ns/10ps
`default_nettype none

`include "jesd204_up_params.svh"

module jesd204_up_regmap (
  input  wire logic                          up_clk,
  input  wire logic                          up_reset,
  input  wire logic                          device_clk,
  input  wire logic                          sysref,
  input  wire logic [`JESD204_UP_ADDR_W-1:0] up_raddr,
  input  wire jesd204_up_pkg::up_wr_t        up_wr,
  output logic      [`JESD204_UP_DATA_W-1:0] up_rdata,
  output logic                               link_enable,
  output logic                               lmfc_edge
);

  localparam int DATA_PATH_WIDTH_LOG2 = `JESD204_DATA_PATH_WIDTH_LOG2;

  logic [`JESD204_UP_DATA_W-1:0] common_rdata;
  logic [`JESD204_UP_DATA_W-1:0] sysref_rdata;
  logic                          up_cfg_is_writeable;
  logic [7:0]                    beats_per_multiframe;   // quasi static.
  jesd204_up_pkg::sysref_cfg_t   sysref_cfg;             // quasi static.
  jesd204_up_pkg::sysref_event_t device_event;           // device_clk.
  jesd204_up_pkg::sysref_event_t up_sysref_event;        // up_clk.

  // ################################################
  // up_clk register blocks
  // ################################################

  jesd204_up_common u_common (
    .up_clk               (up_clk),
    .up_reset             (up_reset),
    .up_raddr             (up_raddr),
    .up_wr                (up_wr),
    .up_rdata             (common_rdata),
    .link_enable          (link_enable),
    .up_cfg_is_writeable  (up_cfg_is_writeable),
    .beats_per_multiframe (beats_per_multiframe)
  );

  jesd204_up_sysref #(
    .DATA_PATH_WIDTH_LOG2 (DATA_PATH_WIDTH_LOG2)
  ) u_sysref (
    .up_clk              (up_clk),
    .up_reset            (up_reset),
    .up_raddr            (up_raddr),
    .up_wr               (up_wr),
    .up_cfg_is_writeable (up_cfg_is_writeable),
    .up_sysref_event     (up_sysref_event),
    .up_rdata            (sysref_rdata),
    .sysref_cfg          (sysref_cfg)
  );

  // blocks return zero off their own addresses.
  assign up_rdata = common_rdata | sysref_rdata;

  // ################################################
  // device clock side
  // ################################################

  sync_event #(
    .NUM_OF_EVENTS ($bits(jesd204_up_pkg::sysref_event_t))
  ) u_sync_event (
    .in_clk    (device_clk),
    .in_event  (device_event),
    .out_clk   (up_clk),
    .out_event (up_sysref_event)
  );

  jesd204_lmfc #(
    .DATA_PATH_WIDTH_LOG2 (DATA_PATH_WIDTH_LOG2)
  ) u_lmfc (
    .device_clk           (device_clk),
    .link_enable          (link_enable),
    .sysref               (sysref),
    .sysref_cfg           (sysref_cfg),
    .beats_per_multiframe (beats_per_multiframe),
    .lmfc_edge            (lmfc_edge),
    .device_event         (device_event)
  );

endmodule

`default_nettype wire

// File: tests/jesd204_up_checker.sv
// concurrent checks on the lmfc edge pulse, the synchronized sysref events
// and link enable after reset, bound into the register block top.

`timescale 1ns/10ps
`default_nettype none

module jesd204_up_checker (
  input wire logic       up_clk,
  input wire logic       up_reset,
  input wire logic       device_clk,
  input wire logic       link_enable,
  input wire logic       lmfc_edge,
  input wire logic [1:0] up_sysref_event
);

  int assert_failures = 0;  // count of failed assertions.

  // ################################################
  // device clock
  // ################################################

  lmfc_edge_single: assert property (
    @(posedge device_clk) disable iff (up_reset) lmfc_edge |=> !lmfc_edge
  ) else begin
    $error("lmfc_edge stayed high for two device clocks");
    assert_failures++;
  end

  // ################################################
  // up_clk
  // ################################################

  edge_event_single: assert property (
    @(posedge up_clk) disable iff (up_reset) up_sysref_event[0] |=> !up_sysref_event[0]
  ) else begin
    $error("sysref edge event lasted more than one up_clk cycle");
    assert_failures++;
  end

  align_event_single: assert property (
    @(posedge up_clk) disable iff (up_reset) up_sysref_event[1] |=> !up_sysref_event[1]
  ) else begin
    $error("alignment error event lasted more than one up_clk cycle");
    assert_failures++;
  end

  // link stays down right after reset.
  link_low_after_reset: assert property (
    @(posedge up_clk) up_reset |=> !link_enable
  ) else begin
    $error("link_enable high in the cycle after reset");
    assert_failures++;
  end

endmodule

bind jesd204_up_regmap jesd204_up_checker u_checker (
  .up_clk          (up_clk),
  .up_reset        (up_reset),
  .device_clk      (device_clk),
  .link_enable     (link_enable),
  .lmfc_edge       (lmfc_edge),
  .up_sysref_event (up_sysref_event)
);

`default_nettype wire

// File: tests/jesd204_up_tb.sv
// testbench for the jesd204 register block: clocks, reset, bus tasks
// and directed register, sysref status and lmfc tests.

`timescale 1ns/10ps
`default_nettype none

`include "jesd204_up_params.svh"

module jesd204_up_tb;

  localparam int MF_BEATS = 10;  // multiframe length under test.

  logic                          up_clk;
  logic                          up_reset;
  logic                          device_clk;
  logic                          sysref;
  logic [`JESD204_UP_ADDR_W-1:0] up_raddr;
  jesd204_up_pkg::up_wr_t        up_wr;
  logic [`JESD204_UP_DATA_W-1:0] up_rdata;
  logic                          link_enable;
  logic                          lmfc_edge;
  int                            dev_cycle = 0;  // device clocks since start.
  int                            sysref_ref;     // cycle of the capturing edge.

  jesd204_up_regmap u_dut (
    .up_clk      (up_clk),
    .up_reset    (up_reset),
    .device_clk  (device_clk),
    .sysref      (sysref),
    .up_raddr    (up_raddr),
    .up_wr       (up_wr),
    .up_rdata    (up_rdata),
    .link_enable (link_enable),
    .lmfc_edge   (lmfc_edge)
  );

  // ################################################
  // clocks
  // ################################################

  initial begin
    up_clk = 1'b0;
    forever #5 up_clk = ~up_clk;  // 100 mhz.
  end

  initial begin
    device_clk = 1'b0;
    forever #4 device_clk = ~device_clk;  // 125 mhz.
  end

  always @(posedge device_clk) begin
    dev_cycle <= dev_cycle + 1;
  end

  // ################################################
  // checking and bus tasks
  // ################################################

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    @(negedge up_clk);
    up_wr.wreq  = 1'b1;
    up_wr.waddr = addr;
    up_wr.wdata = data;
    @(negedge up_clk);
    up_wr.wreq  = 1'b0;  // one strobe cycle.
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    @(negedge up_clk);
    up_raddr = addr;
    #1;
    data = up_rdata;  // combinational read.
  endtask

  task automatic read_check(input string test, input logic [11:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    read_reg(addr, data);
    check_value(test, expected, data);
  endtask

  // polls the sticky status until all bits of mask are set.
  task automatic wait_status(input string test, input logic [1:0] mask);
    logic [31:0] data;
    int          tries;
    tries = 0;
    read_reg(`JESD204_ADDR_SYSREF_STATUS, data);
    while ((data[1:0] & mask) != mask) begin
      tries++;
      if (tries > 40) begin
        $display("%s: status bits 0x%0h did not set within 40 reads", test, mask);
        stop_with_failure();
      end
      read_reg(`JESD204_ADDR_SYSREF_STATUS, data);
    end
  endtask

  // status must stay clear for longer than the event latency.
  task automatic expect_quiet(input string test);
    repeat (30) read_check(test, `JESD204_ADDR_SYSREF_STATUS, 32'h0);
  endtask

  // ################################################
  // device side stimulus
  // ################################################

  // call at a device_clk falling edge.
  task automatic raise_sysref(output int at);
    at = dev_cycle;
    sysref = 1'b1;
    repeat (2) @(negedge device_clk);
    sysref = 1'b0;
  endtask

  // raises sysref at a given beat phase relative to the capturing edge.
  task automatic sysref_at_phase(input string test, input int phase);
    int tries;
    int unused_at;
    tries = 0;
    @(negedge device_clk);
    while (((dev_cycle - sysref_ref) % MF_BEATS) != phase) begin
      tries++;
      if (tries > 4 * MF_BEATS) begin
        $display("%s: lmfc phase %0d never reached", test, phase);
        stop_with_failure();
      end
      @(negedge device_clk);
    end
    raise_sysref(unused_at);
  endtask

  task automatic wait_lmfc_edge(input string test, output int at);
    int tries;
    tries = 0;
    @(negedge device_clk);
    while (!lmfc_edge) begin
      tries++;
      if (tries > 4 * MF_BEATS) begin
        $display("%s: no lmfc_edge within %0d device clocks", test, 4 * MF_BEATS);
        stop_with_failure();
      end
      @(negedge device_clk);
    end
    at = dev_cycle;
  endtask

  // disable, reconfigure and re-enable the link with a clean status.
  task automatic restart_link(input logic [7:0] beats, input logic [31:0] conf);
    write_reg(`JESD204_ADDR_LINK_ENABLE, 32'h0);
    repeat (6) @(negedge up_clk);  // device state clears.
    write_reg(`JESD204_ADDR_MULTIFRAME, {24'h0, beats});
    write_reg(`JESD204_ADDR_SYSREF_CONF, conf);
    write_reg(`JESD204_ADDR_LMFC_OFFSET, 32'h0);
    write_reg(`JESD204_ADDR_LINK_ENABLE, 32'h1);
    repeat (6) @(negedge up_clk);
    write_reg(`JESD204_ADDR_SYSREF_STATUS, 32'h3);
  endtask

  // ################################################
  // directed tests
  // ################################################

  task automatic test_reset_values();
    logic [31:0] value;
    read_check("reset_version", `JESD204_ADDR_VERSION, `JESD204_UP_VERSION);
    read_check("reset_multiframe", `JESD204_ADDR_MULTIFRAME, 32'd16);
    read_check("reset_link_enable", `JESD204_ADDR_LINK_ENABLE, 32'h0);
    check_value("reset_link_pin", 32'h0, 32'(link_enable));  // top level output.
    read_check("reset_sysref_conf", `JESD204_ADDR_SYSREF_CONF, 32'h0);
    read_check("reset_lmfc_offset", `JESD204_ADDR_LMFC_OFFSET, 32'h0);
    read_check("reset_sysref_status", `JESD204_ADDR_SYSREF_STATUS, 32'h0);
    read_check("unmapped_read", 12'h7ff, 32'h0);
    repeat (4) begin
      value = $urandom();
      write_reg(`JESD204_ADDR_SCRATCH, value);
      read_check("scratch", `JESD204_ADDR_SCRATCH, value);
    end
  endtask

  task automatic test_cfg_lock();
    write_reg(`JESD204_ADDR_LMFC_OFFSET, 32'h3ff);
    read_check("offset_align", `JESD204_ADDR_LMFC_OFFSET, 32'h3fc);  // low bits drop.
    write_reg(`JESD204_ADDR_SYSREF_CONF, 32'h3);
    read_check("conf_both", `JESD204_ADDR_SYSREF_CONF, 32'h3);
    write_reg(`JESD204_ADDR_SYSREF_CONF, 32'h2);
    read_check("conf_oneshot", `JESD204_ADDR_SYSREF_CONF, 32'h2);
    write_reg(`JESD204_ADDR_MULTIFRAME, 32'd24);
    read_check("multiframe_write", `JESD204_ADDR_MULTIFRAME, 32'd24);
    write_reg(`JESD204_ADDR_LINK_ENABLE, 32'h1);
    read_check("link_on", `JESD204_ADDR_LINK_ENABLE, 32'h1);
    check_value("link_on_pin", 32'h1, 32'(link_enable));
    write_reg(`JESD204_ADDR_SYSREF_CONF, 32'h1);  // all ignored now.
    write_reg(`JESD204_ADDR_LMFC_OFFSET, 32'h0);
    write_reg(`JESD204_ADDR_MULTIFRAME, 32'd5);
    read_check("conf_locked", `JESD204_ADDR_SYSREF_CONF, 32'h2);
    read_check("offset_locked", `JESD204_ADDR_LMFC_OFFSET, 32'h3fc);
    read_check("multiframe_locked", `JESD204_ADDR_MULTIFRAME, 32'd24);
  endtask

  task automatic test_sysref_status();
    restart_link(8'd16, 32'h0);
    @(negedge device_clk);
    raise_sysref(sysref_ref);
    wait_status("sysref_edge", 2'b01);
    read_check("sysref_no_error", `JESD204_ADDR_SYSREF_STATUS, 32'h1);
    write_reg(`JESD204_ADDR_SYSREF_STATUS, 32'h1);
    read_check("sysref_clear", `JESD204_ADDR_SYSREF_STATUS, 32'h0);
  endtask

  task automatic test_lmfc_period();
    int prev;
    int now;
    restart_link(8'(MF_BEATS), 32'h0);
    wait_lmfc_edge("lmfc_first", prev);
    repeat (5) begin
      wait_lmfc_edge("lmfc_next", now);
      check_value("lmfc_period", 32'(MF_BEATS), 32'(now - prev));
      prev = now;
    end
  endtask

  task automatic test_alignment();
    restart_link(8'(MF_BEATS), 32'h0);
    @(negedge device_clk);
    raise_sysref(sysref_ref);  // capturing edge.
    wait_status("align_capture", 2'b01);
    write_reg(`JESD204_ADDR_SYSREF_STATUS, 32'h3);
    repeat (2) begin
      sysref_at_phase("align_ok", 0);
      wait_status("align_ok", 2'b01);
      read_check("align_ok", `JESD204_ADDR_SYSREF_STATUS, 32'h1);
      write_reg(`JESD204_ADDR_SYSREF_STATUS, 32'h3);
    end
    sysref_at_phase("align_shift", 1);  // one beat late.
    wait_status("align_shift", 2'b01);
    read_check("align_shift", `JESD204_ADDR_SYSREF_STATUS, 32'h3);
  endtask

  task automatic test_oneshot_disable();
    restart_link(8'(MF_BEATS), 32'h2);
    @(negedge device_clk);
    raise_sysref(sysref_ref);
    wait_status("oneshot_first", 2'b01);
    write_reg(`JESD204_ADDR_SYSREF_STATUS, 32'h3);
    sysref_at_phase("oneshot_second", 1);
    expect_quiet("oneshot_second");
    restart_link(8'(MF_BEATS), 32'h1);
    @(negedge device_clk);
    raise_sysref(sysref_ref);
    expect_quiet("sysref_disabled");
  endtask

  // ################################################
  // main sequence
  // ################################################

  initial begin
    void'($urandom(32'hdf5c_f7a8));
    up_reset = 1'b1;
    sysref   = 1'b0;
    up_raddr = '0;
    up_wr    = '0;
    repeat (8) @(negedge up_clk);
    up_reset = 1'b0;
    test_reset_values();
    test_cfg_lock();
    test_sysref_status();
    test_lmfc_period();
    test_alignment();
    test_oneshot_disable();
    if (u_dut.u_checker.assert_failures == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d checker assertions failed", u_dut.u_checker.assert_failures);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
logic/jesd204_up_pkg.sv
logic/sync_event.sv
logic/jesd204_up_common.sv
logic/jesd204_up_sysref.sv
logic/jesd204_lmfc.sv
logic/jesd204_up_regmap.sv
tests/jesd204_up_checker.sv
tests/jesd204_up_tb.sv
